//--- rtl/timing_pkg.sv
`default_nettype none

package timing_pkg;

    //////////////////////////////
    // Timer widths
    //////////////////////////////

    // Wide enough for several seconds at 100 MHz
    typedef logic [28:0] cycle_count_t;

    //////////////////////////////
    // Board-rate timing, 100 MHz clock
    //////////////////////////////

    localparam int default_delay_cycles  = 100_000_000; // Mole hidden for 1 s
    localparam int default_window_cycles = 300_000_000; // Hit window of 3 s
    localparam int default_shrink_cycles = 25_000_000;  // Window cut of 0.25 s per level

endpackage

`default_nettype wire

//--- rtl/game_pkg.sv
`default_nettype none

package game_pkg;

    //////////////////////////////
    // Game flow
    //////////////////////////////

    typedef enum logic [1:0] {
        st_idle, // Waiting for a start press
        st_play, // Moles popping, hits and misses counted
        st_end   // Out of lives, score on show
    } game_state_t;

    //////////////////////////////
    // Player status
    //////////////////////////////

    typedef logic [7:0] score_t; // Hit count, saturates at 255
    typedef logic [3:0] lives_t; // Lives left in the current game
    typedef logic [3:0] level_t; // Speed level, shortens the hit window

endpackage

`default_nettype wire

//--- rtl/press_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module press_decoder #(
    parameter int num_holes = 4
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [num_holes-1:0]  button,  // One level per hole
    input  wire [num_holes-1:0]  mole,    // Currently lit hole
    output logic                 any_press,
    output logic                 exit_press,
    output logic                 hit,
    output logic                 wrong
);

    logic [num_holes-1:0] button_prev; // Button levels at the previous edge
    logic [num_holes-1:0] press;       // Rising edge per hole
    logic                 lit_press;   // Press on a lit hole
    logic                 dark_press;  // Press on an unlit hole

    //////////////////////////////
    // Edge detection
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            button_prev <= '0;
        end else begin
            button_prev <= button;
        end
    end

    assign press = button & ~button_prev; // High now, low last edge

    //////////////////////////////
    // Press classification
    //////////////////////////////

    assign lit_press  = |(press & mole);
    assign dark_press = |(press & ~mole);

    assign any_press  = |press;
    assign exit_press = press[0];        // Hole 0 doubles as the exit key
    assign hit        = lit_press;       // Right hole wins over a stray one
    // Only counts while some mole is up
    assign wrong      = (|mole) && dark_press && !lit_press;

endmodule

`default_nettype wire

//--- rtl/mole_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mole_sequencer #(
    parameter int num_holes     = 4,
    parameter int delay_cycles  = 100,
    parameter int window_cycles = 300,
    parameter int shrink_cycles = 25
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire game_pkg::game_state_t state,
    input  wire game_pkg::level_t  level,
    input  wire                    hit,   // Lit hole pressed
    input  wire                    wrong, // Unlit hole pressed while a mole is up
    output logic [num_holes-1:0]   mole,
    output logic                   miss   // Window ran out with no press
);

    import timing_pkg::*;
    import game_pkg::*;

    localparam int idx_w = (num_holes > 1) ? $clog2(num_holes) : 1;

    typedef logic [idx_w-1:0] hole_idx_t;

    // Mole hidden or shown within a round
    typedef enum logic {
        ph_hidden,
        ph_shown
    } phase_t;

    localparam cycle_count_t            delay_load = cycle_count_t'(delay_cycles - 1);
    localparam logic [num_holes-1:0]    first_hole = 1; // Hole 0 lit, shifted into place

    phase_t       phase;
    cycle_count_t count;      // Edges left in the current phase, minus one
    cycle_count_t window_len; // Hit window at the current level
    hole_idx_t    hole;       // Next hole to light
    hole_idx_t    next_hole;
    logic         shown;
    logic         pressed;    // Hit or wrong press ends the window

    //////////////////////////////
    // Round timing
    //////////////////////////////

    assign shown   = (phase == ph_shown);
    assign pressed = hit || wrong;

    // Faster levels cut a fixed step off the window
    assign window_len = cycle_count_t'(window_cycles)
                      - cycle_count_t'(level) * cycle_count_t'(shrink_cycles);

    // Rotate 0, 1, ..., num_holes-1, 0
    assign next_hole = (hole == hole_idx_t'(num_holes - 1)) ? '0 : hole + 1'b1;

    // A press on the last window edge still counts as a press
    assign miss = shown && (count == '0) && !pressed;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= ph_hidden;
            count <= '0;
            hole  <= '0;
            mole  <= '0;
        end else if (state != st_play) begin
            // First delay sits loaded so it runs from the start edge
            phase <= ph_hidden;
            count <= delay_load;
            hole  <= '0;
            mole  <= '0;
        end else if (!shown) begin
            if (count == '0) begin
                phase <= ph_shown;                 // Mole pops up
                count <= window_len - 1'b1;
                mole  <= first_hole << hole;
            end else begin
                count <= count - 1'b1;
            end
        end else if (pressed || count == '0) begin
            // Hit, wrong press or timeout ends the round
            phase <= ph_hidden;
            count <= delay_load;
            mole  <= '0;
            if (hit) begin
                hole <= next_hole;                 // Only a hit moves on
            end
        end else begin
            count <= count - 1'b1;                 // Window running
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Leaving play always drops the mole first, so no late timeout
    a_miss_in_play: assert property (
        @(posedge clk) disable iff (reset) miss |-> (state == st_play)
    ) else $error("mole_sequencer: miss outside play");

endmodule

`default_nettype wire

//--- rtl/game_control.sv
`timescale 1ns/1ps
`default_nettype none

module game_control #(
    parameter int level_points = 10,
    parameter int max_level    = 9,
    parameter int start_lives  = 3
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    any_press,  // Start key, any hole
    input  wire                    exit_press, // Hole 0, leaves the end screen
    input  wire                    hit,
    input  wire                    wrong,
    input  wire                    miss,
    output game_pkg::game_state_t  state,
    output game_pkg::score_t       score,
    output game_pkg::lives_t       lives,
    output game_pkg::level_t       level
);

    import game_pkg::*;

    localparam int     cnt_w     = (level_points > 1) ? $clog2(level_points) : 1;
    localparam score_t score_max = '1;

    game_state_t       state_next;
    logic [cnt_w-1:0]  hit_count;  // Hits since the last level step
    logic              start;      // Game begins this edge
    logic              lose_life;  // Wrong press or timeout
    logic              last_life;
    logic              level_step; // This hit completes a level

    assign start      = (state == st_idle) && any_press;
    assign lose_life  = (state == st_play) && !hit && (wrong || miss);
    assign last_life  = (lives == lives_t'(1));
    assign level_step = (int'(hit_count) == level_points - 1);

    //////////////////////////////
    // Game FSM
    //////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (any_press) begin
                    state_next = st_play;
                end
            end
            st_play: begin
                if (lose_life && last_life) begin
                    state_next = st_end;      // Last life gone
                end
            end
            st_end: begin
                if (exit_press) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////
    // Score, level and lives
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score     <= '0;
            lives     <= '0;
            level     <= '0;
            hit_count <= '0;
        end else if (start) begin
            score     <= '0;                        // Fresh game
            lives     <= lives_t'(start_lives);
            level     <= '0;
            hit_count <= '0;
        end else if (state == st_play && hit) begin
            if (score != score_max) begin
                score <= score + 1'b1;              // Holds at 255
            end
            if (level_step) begin
                hit_count <= '0;
                if (level < level_t'(max_level)) begin
                    level <= level + 1'b1;          // Speed up
                end
            end else begin
                hit_count <= hit_count + 1'b1;
            end
        end else if (lose_life) begin
            lives <= lives - 1'b1;
        end
    end

    // A lost life never arrives once the game is out of lives
    a_lives_no_underflow: assert property (
        @(posedge clk) disable iff (reset) lose_life |-> (lives != '0)
    ) else $error("game_control: life lost with zero lives");

endmodule

`default_nettype wire

//--- rtl/whack_a_mole.sv
`timescale 1ns/1ps
`default_nettype none

module whack_a_mole #(
    parameter int num_holes     = 4,
    parameter int delay_cycles  = timing_pkg::default_delay_cycles,
    parameter int window_cycles = timing_pkg::default_window_cycles,
    parameter int shrink_cycles = timing_pkg::default_shrink_cycles,
    parameter int level_points  = 10,
    parameter int max_level     = 9,
    parameter int start_lives   = 3
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [num_holes-1:0]    button,
    output logic [num_holes-1:0]   mole,
    output game_pkg::score_t       score,
    output game_pkg::lives_t       lives,
    output game_pkg::game_state_t  state
);

    import game_pkg::*;

    logic   any_press;
    logic   exit_press;
    logic   hit;
    logic   wrong;
    logic   miss;
    level_t level;

    //////////////////////////////
    // Decode, buttons to strobes
    //////////////////////////////

    press_decoder #(
        .num_holes (num_holes)
    ) press_decoder_i (
        .clk        (clk),
        .reset      (reset),
        .button     (button),
        .mole       (mole),
        .any_press  (any_press),
        .exit_press (exit_press),
        .hit        (hit),
        .wrong      (wrong)
    );

    //////////////////////////////
    // Execute, mole timing
    //////////////////////////////

    mole_sequencer #(
        .num_holes     (num_holes),
        .delay_cycles  (delay_cycles),
        .window_cycles (window_cycles),
        .shrink_cycles (shrink_cycles)
    ) mole_sequencer_i (
        .clk   (clk),
        .reset (reset),
        .state (state),
        .level (level),
        .hit   (hit),
        .wrong (wrong),
        .mole  (mole),
        .miss  (miss)
    );

    //////////////////////////////
    // Result, game state
    //////////////////////////////

    game_control #(
        .level_points (level_points),
        .max_level    (max_level),
        .start_lives  (start_lives)
    ) game_control_i (
        .clk        (clk),
        .reset      (reset),
        .any_press  (any_press),
        .exit_press (exit_press),
        .hit        (hit),
        .wrong      (wrong),
        .miss       (miss),
        .state      (state),
        .score      (score),
        .lives      (lives),
        .level      (level)
    );

endmodule

`default_nettype wire

//--- tb/tb_whack_a_mole.sv
`timescale 1ns/1ps
`default_nettype none

module tb_whack_a_mole;

    import game_pkg::*;

    localparam int num_holes     = 4;
    localparam int delay_cycles  = 20;
    localparam int window_cycles = 60;
    localparam int shrink_cycles = 5;
    localparam int level_points  = 3;
    localparam int max_level     = 9;
    localparam int start_lives   = 3;
    localparam int games         = 5;
    localparam int max_rounds    = 48; // Rounds per game before only timeouts remain
    localparam int margin        = 10; // Slack cycles per round
    localparam int watchdog_cycles = games * max_rounds * (delay_cycles + window_cycles + margin);

    logic                 clk;
    logic                 reset;
    logic [num_holes-1:0] button;
    logic [num_holes-1:0] mole;
    score_t               score;
    lives_t               lives;
    game_state_t          state;

    // Reference model of the game
    game_state_t exp_state;
    int          exp_hole;   // Hole the next mole lights
    int          exp_score;
    int          exp_lives;
    int          exp_level;
    int          exp_hits;   // Hits toward the next level
    int unsigned rng;        // LCG state
    int          errors;
    int          checks;

    whack_a_mole #(
        .num_holes     (num_holes),
        .delay_cycles  (delay_cycles),
        .window_cycles (window_cycles),
        .shrink_cycles (shrink_cycles),
        .level_points  (level_points),
        .max_level     (max_level),
        .start_lives   (start_lives)
    ) whack_a_mole_i (
        .clk    (clk),
        .reset  (reset),
        .button (button),
        .mole   (mole),
        .score  (score),
        .lives  (lives),
        .state  (state)
    );

    //////////////////////////////
    // Clock and watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired, games did not finish within %0d cycles", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic int unsigned rand_next();
        rng = rng * 32'd1103515245 + 32'd12345;
        return (rng >> 16) & 32'h7fff; // Upper bits are the better ones
    endfunction

    task automatic check_eq(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_status(input string name);
        check_eq({name, " state"}, int'(exp_state), int'(state));
        check_eq({name, " score"}, exp_score, int'(score));
        check_eq({name, " lives"}, exp_lives, int'(lives));
    endtask

    // Starts on a falling edge and returns on the falling edge after the press
    task automatic pulse_button(input int hole);
        button       = '0;
        button[hole] = 1'b1;
        @(negedge clk);
        button       = '0;
    endtask

    // Counts edges until the mole rises or falls or the limit runs out
    task automatic wait_for_mole(input logic want_lit, input int limit, output int edges);
        edges = 0;
        while (((mole != '0) != want_lit) && edges <= limit) begin
            @(negedge clk);
            edges++;
        end
        checks++;
        assert ((mole != '0) == want_lit) else begin
            errors++;
            $display("Mole did not %s within %0d cycles", want_lit ? "rise" : "fall", limit);
        end
    endtask

    task automatic model_hit();
        exp_score = (exp_score < 255) ? exp_score + 1 : 255; // Saturates
        exp_hits++;
        if (exp_hits == level_points) begin
            exp_hits = 0;
            if (exp_level < max_level) begin
                exp_level++;
            end
        end
        exp_hole = (exp_hole + 1) % num_holes; // Only a hit rotates
    endtask

    task automatic model_lose_life();
        exp_lives--;
        if (exp_lives == 0) begin
            exp_state = st_end;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        int edges;
        int action;
        int press_at;
        int window;
        int wrong_hole;
        int round;

        reset  = 1'b1;
        button = '0;
        rng    = 65;
        errors = 0;
        checks = 0;
        repeat (3) @(negedge clk);
        reset  = 1'b0;

        exp_state = st_idle;
        exp_score = 0;
        exp_lives = 0;
        check_status("reset");
        check_eq("reset mole", 0, int'(mole));

        for (int g = 0; g < games; g++) begin
            @(negedge clk); // Buttons stay low for an edge so the start press is a new edge
            pulse_button(rand_next() % num_holes); // Any hole starts a game
            exp_state = st_play;
            exp_score = 0;
            exp_lives = start_lives;
            exp_level = 0;
            exp_hits  = 0;
            exp_hole  = 0;
            check_status("start");
            round = 0;

            while (exp_state == st_play) begin
                wait_for_mole(1'b1, delay_cycles + margin, edges);
                check_eq("mole delay", delay_cycles, edges);
                check_eq("mole hole", 1 << exp_hole, int'(mole));
                window = window_cycles - exp_level * shrink_cycles; // Shrinks per level

                // 0 to 5 hit, 6 wrong press, 7 let it expire
                action = rand_next() % 8;
                if (round >= max_rounds - start_lives) begin
                    action = 7;
                end

                if (action == 7) begin
                    wait_for_mole(1'b0, window + margin, edges);
                    check_eq("window length", window, edges);
                    model_lose_life();
                    check_status("timeout");
                end else begin
                    // Press lands 1 to window-1 edges after the rise
                    press_at = 1 + rand_next() % (window - 1);
                    repeat (press_at - 1) @(negedge clk);
                    check_eq("mole held", 1 << exp_hole, int'(mole));
                    if (action < 6) begin
                        pulse_button(exp_hole);
                        model_hit();
                        check_status("hit");
                    end else begin
                        wrong_hole = (exp_hole + 1 + rand_next() % (num_holes - 1)) % num_holes;
                        pulse_button(wrong_hole);
                        model_lose_life();
                        check_status("wrong press");
                    end
                end
                check_eq("mole after round", 0, int'(mole));
                round++;
            end

            // End screen keeps the score until hole 0 is pressed
            repeat (5) @(negedge clk);
            check_status("end hold");
            check_eq("end mole", 0, int'(mole));
            pulse_button(0);
            exp_state = st_idle;
            check_status("exit");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/timing_pkg.sv
rtl/game_pkg.sv
rtl/press_decoder.sv
rtl/mole_sequencer.sv
rtl/game_control.sv
rtl/whack_a_mole.sv
tb/tb_whack_a_mole.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the whack-a-mole testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_whack_a_mole -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "All tests passed!" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
